// ==== hdl/addr_decoder.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"
`default_nettype none

module addr_decoder
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  bus_req_t req_i,
  output bus_req_t rom_req_o,
  output bus_req_t clint_req_o,
  input  bus_rsp_t rom_rsp_i,
  input  bus_rsp_t clint_rsp_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned NumRules = 2;

  addr_rule_t addr_map [NumRules];
  target_e    tgt;
  logic       err_hit_q;
  bus_rsp_t   err_rsp;

  // ------------------------------------------------------------
  // address map
  // ------------------------------------------------------------
  assign addr_map[0] = '{
    idx:        TGT_ROM,
    start_addr: `ROM_BASE,
    end_addr:   `ROM_BASE + `ROM_LENGTH
  };
  assign addr_map[1] = '{
    idx:        TGT_CLINT,
    start_addr: `CLINT_BASE,
    end_addr:   `CLINT_BASE + `CLINT_LENGTH
  };

  // unmatched addresses fall to TGT_NONE
  always_comb begin
    tgt = TGT_NONE;
    for (int i = 0; i < NumRules; i++) begin
      if (req_i.addr >= addr_map[i].start_addr && req_i.addr < addr_map[i].end_addr) begin
        tgt = addr_map[i].idx;
      end
    end
  end

  // ------------------------------------------------------------
  // request fan-out
  // ------------------------------------------------------------
  always_comb begin
    rom_req_o         = req_i;
    clint_req_o       = req_i;
    rom_req_o.valid   = req_i.valid && (tgt == TGT_ROM);
    clint_req_o.valid = req_i.valid && (tgt == TGT_CLINT);
  end

  // decode error answered one cycle later, like a target
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      err_hit_q <= 1'b0;
    end else begin
      err_hit_q <= req_i.valid && (tgt == TGT_NONE);
    end
  end

  assign err_rsp = '{valid: err_hit_q, err: err_hit_q, rdata: '0};

  // ------------------------------------------------------------
  // response merge
  // ------------------------------------------------------------
  // idle targets may hold stale data, so each source is
  // masked by its own valid before the OR
  assign rsp_o = bus_rsp_t'(
      (rom_rsp_i & {$bits(bus_rsp_t){rom_rsp_i.valid}})
    | (clint_rsp_i & {$bits(bus_rsp_t){clint_rsp_i.valid}})
    | err_rsp);

endmodule

`default_nettype wire

// ==== hdl/boot_rom.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"
`default_nettype none

module boot_rom
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned IdxWidth   = $clog2(`ROM_WORDS);
  localparam int unsigned UpperWidth = `DATA_WIDTH - 32;

  data_t               rom_table [`ROM_WORDS];
  logic [IdxWidth-1:0] idx;
  logic                valid_q;
  logic                err_q;
  data_t               rdata_q;

  // word i carries its index above the tag
  for (genvar i = 0; i < `ROM_WORDS; i++) begin : gen_table
    assign rom_table[i] = {UpperWidth'(i), `ROM_TAG};
  end

  // 64-bit words, region aliases every 16 words
  assign idx = req_i.addr[3 +: IdxWidth];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      err_q   <= req_i.valid && req_i.we;
    end
  end

  // writes are rejected with zero data
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= req_i.we ? '0 : rom_table[idx];
    end
  end

  assign rsp_o = '{valid: valid_q, err: err_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== hdl/bus_cut.sv ====
`timescale 1ns/1ps
`default_nettype none

// one register stage for any valid-tagged payload
module bus_cut
  import soc_pkg::*;
#(
  parameter type payload_t = bus_req_t
) (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  payload_t data_i,
  output payload_t data_o
);

  payload_t data_q;

  // whole payload cleared so the valid field drops in reset
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      data_q <= '0;
    end else begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;

endmodule

`default_nettype wire

// ==== hdl/clint_timer.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"
`default_nettype none

module clint_timer
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     rtc_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  localparam logic [15:0] MsipOff     = `CLINT_MSIP_OFFSET;
  localparam logic [15:0] MtimecmpOff = `CLINT_MTIMECMP_OFFSET;
  localparam logic [15:0] MtimeOff    = `CLINT_MTIME_OFFSET;

  logic        rtc_div_q;
  logic        tick;
  data_t       mtime_q;
  data_t       mtimecmp_q;
  logic        msip_q;
  logic [15:0] offset;
  logic        wr_en;
  data_t       rd_data;
  logic        valid_q;
  data_t       rdata_q;

  // byte-lane merge of write data into a register
  function automatic data_t apply_be(data_t old_val, data_t wdata, strb_t be);
    data_t res;
    for (int b = 0; b < `STRB_WIDTH; b++) begin
      res[8*b +: 8] = be[b] ? wdata[8*b +: 8] : old_val[8*b +: 8];
    end
    return res;
  endfunction

  assign offset = req_i.addr[15:0];
  assign wr_en  = req_i.valid && req_i.we;

  // ------------------------------------------------------------
  // rtc divide by two
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_div_q <= 1'b0;
    end else if (rtc_i) begin
      rtc_div_q <= ~rtc_div_q;
    end
  end

  // every second strobe
  assign tick = rtc_i && rtc_div_q;

  // ------------------------------------------------------------
  // timer and software interrupt registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      // a bus write to mtime wins over the tick
      if (wr_en && offset == MtimeOff) begin
        mtime_q <= apply_be(mtime_q, req_i.wdata, req_i.be);
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && offset == MtimecmpOff) begin
        mtimecmp_q <= apply_be(mtimecmp_q, req_i.wdata, req_i.be);
      end
      if (wr_en && offset == MsipOff && req_i.be[0]) begin
        msip_q <= req_i.wdata[0];
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (offset)
      MsipOff:     rd_data[0] = msip_q;
      MtimecmpOff: rd_data    = mtimecmp_q;
      MtimeOff:    rd_data    = mtime_q;
      default:     rd_data    = '0;
    endcase
  end

  // ------------------------------------------------------------
  // response
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= req_i.we ? '0 : rd_data;
    end
  end

  // unknown offsets are not errors here
  assign rsp_o = '{valid: valid_q, err: 1'b0, rdata: rdata_q};

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// ==== hdl/debug_req_gate.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"
`default_nettype none

// holds off debug requests while boot code runs after reset
module debug_req_gate
  import soc_pkg::*;
(
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  dbg_cnt_t cnt_q;

  // counts down once and then parks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= dbg_cnt_t'(`DEBUG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

`default_nettype wire

// ==== hdl/soc_pkg.sv ====
`include "soc_settings.svh"
`default_nettype none

package soc_pkg;

  // ------------------------------------------------------------
  // basic words
  // ------------------------------------------------------------
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`STRB_WIDTH-1:0] strb_t;

  // single-cycle request strobe
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t be;
  } bus_req_t;

  // single-cycle response pulse
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  // ------------------------------------------------------------
  // address decoding
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_CLINT = 2'd1,
    TGT_NONE  = 2'd2
  } target_e;

  // end_addr is exclusive
  typedef struct packed {
    target_e idx;
    addr_t   start_addr;
    addr_t   end_addr;
  } addr_rule_t;

  // wide enough to hold the full delay value
  typedef logic [$clog2(`DEBUG_DELAY_CYCLES + 1)-1:0] dbg_cnt_t;

endpackage

`default_nettype wire

// ==== hdl/soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

`default_nettype none

// ------------------------------------------------------------
// bus widths
// ------------------------------------------------------------
`define ADDR_WIDTH 32
`define DATA_WIDTH 64
`define STRB_WIDTH 8

// ------------------------------------------------------------
// address map
// ------------------------------------------------------------
`define ROM_BASE     32'h0001_0000
`define ROM_LENGTH   32'h0001_0000
`define CLINT_BASE   32'h0200_0000
`define CLINT_LENGTH 32'h000C_0000

// clint register offsets within the region
`define CLINT_MSIP_OFFSET     16'h0000
`define CLINT_MTIMECMP_OFFSET 16'h4000
`define CLINT_MTIME_OFFSET    16'hBFF8

// boot rom contents
`define ROM_WORDS 16
`define ROM_TAG   32'hb007_c0de

// cycles before a debug request may reach the core
`define DEBUG_DELAY_CYCLES 64

`default_nettype wire

`endif

// ==== hdl/soc_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_subsystem
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  input  logic     rtc_i,
  input  logic     debug_req_i,
  output logic     debug_req_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  bus_req_t req_cut;
  bus_req_t rom_req;
  bus_req_t clint_req;
  bus_rsp_t rom_rsp;
  bus_rsp_t clint_rsp;
  bus_rsp_t rsp_merged;

  // ------------------------------------------------------------
  // debug gating
  // ------------------------------------------------------------
  debug_req_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  // ------------------------------------------------------------
  // cuts and address map
  // ------------------------------------------------------------
  bus_cut #(
    .payload_t ( bus_req_t )
  ) i_req_cut (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .data_i     ( bus_req_i  ),
    .data_o     ( req_cut    )
  );

  addr_decoder i_decoder (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req_cut    ),
    .rom_req_o   ( rom_req    ),
    .clint_req_o ( clint_req  ),
    .rom_rsp_i   ( rom_rsp    ),
    .clint_rsp_i ( clint_rsp  ),
    .rsp_o       ( rsp_merged )
  );

  bus_cut #(
    .payload_t ( bus_rsp_t )
  ) i_rsp_cut (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .data_i     ( rsp_merged ),
    .data_o     ( bus_rsp_o  )
  );

  // ------------------------------------------------------------
  // targets
  // ------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( rom_req    ),
    .rsp_o      ( rom_rsp    )
  );

  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/soc_pkg.sv
hdl/bus_cut.sv
hdl/addr_decoder.sv
hdl/boot_rom.sv
hdl/clint_timer.sv
hdl/debug_req_gate.sv
hdl/soc_subsystem.sv
tests/soc_subsystem_properties.sv
tests/soc_subsystem_tb.sv

// ==== tests/soc_subsystem_properties.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"
`default_nettype none

module soc_subsystem_properties
  import soc_pkg::*;
(
  input logic     clk_i,
  input logic     ndmreset_n,
  input bus_req_t req_i,
  input bus_rsp_t rsp_i,
  input logic     debug_req_i,
  input logic     ipi_i
);

  int unsigned fail_count = 0;
  int unsigned win_cnt;
  logic        in_rom;
  logic        in_clint;
  logic        err_exp;

  assign in_rom   = req_i.addr >= `ROM_BASE && req_i.addr < (`ROM_BASE + `ROM_LENGTH);
  assign in_clint = req_i.addr >= `CLINT_BASE && req_i.addr < (`CLINT_BASE + `CLINT_LENGTH);
  assign err_exp  = !(in_rom || in_clint) || (in_rom && req_i.we);

  // cycles since reset release, parks at the end of the window
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      win_cnt <= 0;
    end else if (win_cnt < `DEBUG_DELAY_CYCLES) begin
      win_cnt <= win_cnt + 1;
    end
  end

  // ------------------------------------------------------------
  // bus latency and error flag
  // ------------------------------------------------------------
  a_rsp_latency: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i.valid |-> ##3 rsp_i.valid)
    else begin
      $error("no response three cycles after a request");
      fail_count++;
    end

  a_err_flag: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i.valid |-> ##3 (rsp_i.err == $past(err_exp, 3)))
    else begin
      $error("error flag does not match the decoded target");
      fail_count++;
    end

  // ------------------------------------------------------------
  // side-band outputs
  // ------------------------------------------------------------
  a_debug_window: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (win_cnt < `DEBUG_DELAY_CYCLES) |-> !debug_req_i)
    else begin
      $error("debug request passed inside the delay window");
      fail_count++;
    end

  // msip bit 0 lands two cycles after the write enters the top
  a_ipi_msip: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (req_i.valid && req_i.we && in_clint && req_i.be[0]
     && req_i.addr[15:0] == `CLINT_MSIP_OFFSET)
    |-> ##2 (ipi_i == $past(req_i.wdata[0], 2)))
    else begin
      $error("software interrupt output does not follow the msip write");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== tests/soc_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"
`default_nettype none

module soc_subsystem_tb
  import soc_pkg::*;
();

  localparam int    MaxCycles = 2000;
  localparam addr_t MsipAddr  = `CLINT_BASE + `CLINT_MSIP_OFFSET;
  localparam addr_t CmpAddr   = `CLINT_BASE + `CLINT_MTIMECMP_OFFSET;
  localparam addr_t MtimeAddr = `CLINT_BASE + `CLINT_MTIME_OFFSET;

  logic     clk;
  logic     ndmreset_n;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic     rtc;
  logic     debug_req;
  logic     debug_req_gated;
  logic     timer_irq;
  logic     ipi;

  int       seed = 32'hd05b_1c3a;
  int       cycles = 0;
  bus_rsp_t exp_q [$];
  bus_rsp_t exp_rsp;
  data_t    model_mtime;
  data_t    model_mtimecmp;
  logic     model_msip;
  logic     rtc_phase;

  soc_subsystem i_dut (
    .clk_i       ( clk             ),
    .ndmreset_n  ( ndmreset_n      ),
    .bus_req_i   ( bus_req         ),
    .bus_rsp_o   ( bus_rsp         ),
    .rtc_i       ( rtc             ),
    .debug_req_i ( debug_req       ),
    .debug_req_o ( debug_req_gated ),
    .timer_irq_o ( timer_irq       ),
    .ipi_o       ( ipi             )
  );

  bind soc_subsystem soc_subsystem_properties i_props (
    .clk_i       ( clk_i          ),
    .ndmreset_n  ( ndmreset_n     ),
    .req_i       ( bus_req_i      ),
    .rsp_i       ( bus_rsp_o      ),
    .debug_req_i ( debug_req_o    ),
    .ipi_i       ( ipi_o          )
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  function automatic data_t merge_bytes(input data_t old_val, input data_t wdata, input strb_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < `STRB_WIDTH; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------------------------------------
  // reference model of the address map and targets
  // ------------------------------------------------------------
  function automatic bus_rsp_t predict(input logic we, input addr_t addr, input data_t wdata,
                                       input strb_t be);
    bus_rsp_t rsp;
    rsp = '{valid: 1'b1, err: 1'b0, rdata: '0};
    if (addr >= `ROM_BASE && addr < (`ROM_BASE + `ROM_LENGTH)) begin
      rsp.err = we;
      if (!we) begin
        rsp.rdata = {32'(addr[6:3]), `ROM_TAG};
      end
    end else if (addr >= `CLINT_BASE && addr < (`CLINT_BASE + `CLINT_LENGTH)) begin
      if (we) begin
        case (addr[15:0])
          `CLINT_MSIP_OFFSET:     model_msip = be[0] ? wdata[0] : model_msip;
          `CLINT_MTIMECMP_OFFSET: model_mtimecmp = merge_bytes(model_mtimecmp, wdata, be);
          `CLINT_MTIME_OFFSET:    model_mtime = merge_bytes(model_mtime, wdata, be);
          default: ;
        endcase
      end else begin
        case (addr[15:0])
          `CLINT_MSIP_OFFSET:     rsp.rdata = data_t'(model_msip);
          `CLINT_MTIMECMP_OFFSET: rsp.rdata = model_mtimecmp;
          `CLINT_MTIME_OFFSET:    rsp.rdata = model_mtime;
          default:                rsp.rdata = '0;
        endcase
      end
    end else begin
      rsp.err = 1'b1;
    end
    return rsp;
  endfunction

  // one request per call, one cycle long
  task automatic issue(input logic we, input addr_t addr, input data_t wdata, input strb_t be);
    exp_q.push_back(predict(we, addr, wdata, be));
    bus_req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata, be: be};
    @(negedge clk);
    bus_req.valid = 1'b0;
  endtask

  // every second strobe advances the timer
  task automatic pulse_rtc(input int n);
    repeat (n) begin
      rtc = 1'b1;
      if (rtc_phase) begin
        model_mtime++;
      end
      rtc_phase = ~rtc_phase;
      @(negedge clk);
      rtc = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_irq();
    assert (timer_irq == (model_mtime >= model_mtimecmp) && ipi == model_msip)
      else abort_run("Interrupt outputs differ from the timer model");
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MaxCycles) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  // responses are stable at the falling edge
  always @(negedge clk) begin
    if (i_dut.i_props.fail_count != 0) begin
      abort_run("A bound assertion on the DUT failed");
    end else if (bus_rsp.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("A response arrived with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        assert (bus_rsp == exp_rsp) else abort_run($sformatf(
          "Mismatch at %0t: err %0b rdata %h, expected err %0b rdata %h",
          $time, bus_rsp.err, bus_rsp.rdata, exp_rsp.err, exp_rsp.rdata));
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    int sel;
    bus_req        = '0;
    rtc            = 1'b0;
    debug_req      = 1'b1;
    ndmreset_n     = 1'b0;
    model_mtime    = '0;
    model_mtimecmp = '1;
    model_msip     = 1'b0;
    rtc_phase      = 1'b0;
    repeat (2) @(negedge clk);
    ndmreset_n = 1'b1;

    // debug request held high from reset
    for (int k = 0; k < `DEBUG_DELAY_CYCLES; k++) begin
      assert (!debug_req_gated) else abort_run("Debug request passed inside the delay window");
      @(negedge clk);
    end
    repeat (4) begin
      assert (debug_req_gated == debug_req) else abort_run("Debug request does not follow input");
      debug_req = ~debug_req;
      @(negedge clk);
    end

    // rom reads, aliasing across the whole region
    repeat (64) issue(1'b0, `ROM_BASE | addr_t'($random(seed) & 32'h0000_fff8), '0, '1);

    // rejected accesses
    issue(1'b1, `ROM_BASE + 32'h48, {$random(seed), $random(seed)}, '1);
    issue(1'b0, `ROM_BASE - 32'h8, '0, '1);
    issue(1'b0, `ROM_BASE + `ROM_LENGTH, '0, '1);
    issue(1'b1, `CLINT_BASE + `CLINT_LENGTH, '1, '1);
    repeat (8) issue(1'($random(seed)), 32'h8000_0000 | $random(seed), '1, '1);

    // masked writes to mtimecmp and msip
    issue(1'b1, CmpAddr, {$random(seed), $random(seed)}, 8'h36);
    issue(1'b0, CmpAddr, '0, '1);
    issue(1'b1, MsipAddr, 64'h3, 8'h01);
    issue(1'b0, MsipAddr, '0, '1);
    wait_responses();
    check_irq();
    issue(1'b1, MsipAddr, 64'h0, 8'hfe);
    issue(1'b0, MsipAddr, '0, '1);
    wait_responses();
    check_irq();

    // timer against a compare value
    issue(1'b1, MtimeAddr, 64'h100, '1);
    issue(1'b1, CmpAddr, 64'h105, '1);
    wait_responses();
    check_irq();
    pulse_rtc(9);
    issue(1'b0, MtimeAddr, '0, '1);
    wait_responses();
    check_irq();
    pulse_rtc(3);
    issue(1'b0, MtimeAddr, '0, '1);
    wait_responses();
    check_irq();

    // back-to-back mix of all targets
    repeat (300) begin
      sel = $unsigned($random(seed)) % 3;
      if (sel == 0) begin
        issue(1'b0, `ROM_BASE | addr_t'($random(seed) & 32'h0000_fff8), '0, '1);
      end else if (sel == 1) begin
        issue(1'($random(seed)), `CLINT_BASE | addr_t'($random(seed) & 32'h0000_fff8),
              {$random(seed), $random(seed)}, 8'($random(seed)));
      end else begin
        issue(1'($random(seed)), 32'h4000_0000 | $random(seed), '1, '1);
      end
    end
    wait_responses();
    check_irq();

    if (i_dut.i_props.fail_count != 0) begin
      abort_run("A bound assertion on the DUT failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
